// File: afu_csr_pkg.sv
/* AFU register map, ID constant and read engine limits.
   Shared by the CSR file, the engine and the testbench data */
package afu_csr_pkg;

   // Dword offsets, each register spans two dwords
   localparam logic [ccip_if_pkg::mmio_addr_w-1:0] csr_afu_id    = 16'h0000;
   localparam logic [ccip_if_pkg::mmio_addr_w-1:0] csr_scratch   = 16'h0002;
   localparam logic [ccip_if_pkg::mmio_addr_w-1:0] csr_src_addr  = 16'h0004;
   localparam logic [ccip_if_pkg::mmio_addr_w-1:0] csr_num_lines = 16'h0006;
   localparam logic [ccip_if_pkg::mmio_addr_w-1:0] csr_ctrl      = 16'h0008;
   localparam logic [ccip_if_pkg::mmio_addr_w-1:0] csr_status    = 16'h000a;
   localparam logic [ccip_if_pkg::mmio_addr_w-1:0] csr_checksum  = 16'h000c;

   // Read-only ID
   localparam logic [ccip_if_pkg::data_w-1:0] afu_id_value = 64'h5eed_ac1e_0c0d_0001;

   localparam int max_lines_w = 8;   // Up to 255 lines per job

   // Bit positions
   localparam int ctrl_start_bit  = 0;
   localparam int status_done_bit = 0;
   localparam int status_busy_bit = 1;

endpackage

// File: afu_csr_regs.sv
/* MMIO register file of the AFU. Decodes offsets from the demux, answers
   reads on c2 one cycle after the strobe and drives the read engine */
`timescale 1ns/1ps

module afu_csr_regs (
   input  logic                                pClk,
   input  logic                                arst_n,
   input  logic                                mmio_rd_strb,
   input  logic                                mmio_wr_strb,
   input  logic [ccip_if_pkg::mmio_addr_w-1:0] mmio_addr,
   input  logic [ccip_if_pkg::tid_w-1:0]       mmio_tid,
   input  logic [ccip_if_pkg::data_w-1:0]      mmio_wdata,
   input  logic                                busy,
   input  logic                                done,
   input  logic [ccip_if_pkg::data_w-1:0]      checksum,
   output logic                                start_pulse,
   output logic [ccip_if_pkg::line_addr_w-1:0] src_addr,
   output logic [afu_csr_pkg::max_lines_w-1:0] num_lines,
   output logic                                tx_c2_valid,
   output logic [ccip_if_pkg::tid_w-1:0]       tx_c2_tid,
   output logic [ccip_if_pkg::data_w-1:0]      tx_c2_data
);

   logic [ccip_if_pkg::data_w-1:0] scratch;   // Free host scratch
   logic [ccip_if_pkg::data_w-1:0] rd_data;   // Read mux result

   // Read mux
   always_comb begin
      rd_data = '0;                           // Unmapped reads give zero
      case (mmio_addr)
         afu_csr_pkg::csr_afu_id:    rd_data = afu_csr_pkg::afu_id_value;
         afu_csr_pkg::csr_scratch:   rd_data = scratch;
         afu_csr_pkg::csr_src_addr:  rd_data[ccip_if_pkg::line_addr_w-1:0] = src_addr;
         afu_csr_pkg::csr_num_lines: rd_data[afu_csr_pkg::max_lines_w-1:0] = num_lines;
         afu_csr_pkg::csr_status: begin
            rd_data[afu_csr_pkg::status_done_bit] = done;
            rd_data[afu_csr_pkg::status_busy_bit] = busy;
         end
         afu_csr_pkg::csr_checksum:  rd_data = checksum;
         default: ;                           // ctrl is self-clearing, reads zero
      endcase
   end

   // Writable registers and start
   always_ff @(posedge pClk or negedge arst_n) begin
      if (!arst_n) begin
         scratch     <= '0;
         src_addr    <= '0;
         num_lines   <= '0;
         start_pulse <= 1'b0;
      end else begin
         start_pulse <= 1'b0;                 // Single cycle
         if (mmio_wr_strb) begin
            case (mmio_addr)
               afu_csr_pkg::csr_scratch:
                  scratch <= mmio_wdata;
               afu_csr_pkg::csr_src_addr:
                  src_addr <= mmio_wdata[ccip_if_pkg::line_addr_w-1:0];
               afu_csr_pkg::csr_num_lines:
                  num_lines <= mmio_wdata[afu_csr_pkg::max_lines_w-1:0];
               afu_csr_pkg::csr_ctrl:
                  start_pulse <= mmio_wdata[afu_csr_pkg::ctrl_start_bit];
               default: ;                     // ID, status, checksum read-only
            endcase
         end
      end
   end

   // c2 response valid
   always_ff @(posedge pClk or negedge arst_n) begin
      if (!arst_n)
         tx_c2_valid <= 1'b0;
      else
         tx_c2_valid <= mmio_rd_strb;
   end

   // Response payload with its tid
   always_ff @(posedge pClk) begin
      if (mmio_rd_strb) begin
         tx_c2_tid  <= mmio_tid;
         tx_c2_data <= rd_data;
      end
   end

   // Every MMIO read answered next cycle with the same tid
   a_rd_rsp: assert property (@(posedge pClk) disable iff (!arst_n)
      mmio_rd_strb |=> (tx_c2_valid && (tx_c2_tid == $past(mmio_tid))));

endmodule

// File: afu_read_engine.sv
/* Read engine. After a start it issues num_lines c0 read requests, pausing
   under almost-full, and sums the 64-bit response data into a checksum */
`timescale 1ns/1ps

module afu_read_engine (
   input  logic                                pClk,
   input  logic                                arst_n,
   input  logic                                start_pulse,
   input  logic [ccip_if_pkg::line_addr_w-1:0] src_addr,
   input  logic [afu_csr_pkg::max_lines_w-1:0] num_lines,
   input  logic                                rx_c0_almfull,
   input  logic                                rsp_strb,
   input  logic [ccip_if_pkg::data_w-1:0]      rsp_data,
   output logic                                tx_c0_valid,
   output logic [ccip_if_pkg::line_addr_w-1:0] tx_c0_addr,
   output logic [ccip_if_pkg::mdata_w-1:0]     tx_c0_mdata,
   output logic                                busy,
   output logic                                done,
   output logic [ccip_if_pkg::data_w-1:0]      checksum
);

   logic [afu_csr_pkg::max_lines_w-1:0] sent_cnt;    // Requests issued
   logic [afu_csr_pkg::max_lines_w-1:0] rcvd_cnt;    // Responses counted
   logic [afu_csr_pkg::max_lines_w-1:0] lines_r;     // Job length
   logic [ccip_if_pkg::line_addr_w-1:0] base_addr;   // Job start line
   logic [ccip_if_pkg::line_addr_w-1:0] line_idx;    // sent_cnt widened
   logic                                issue;       // Request on next edge

   // Almfull seen now holds off the request of the next cycle
   assign issue = busy && (sent_cnt != lines_r) && !rx_c0_almfull;

   assign line_idx =
      {{(ccip_if_pkg::line_addr_w - afu_csr_pkg::max_lines_w){1'b0}}, sent_cnt};

   always_ff @(posedge pClk or negedge arst_n) begin
      if (!arst_n) begin
         busy        <= 1'b0;
         done        <= 1'b0;
         tx_c0_valid <= 1'b0;
         sent_cnt    <= '0;
         rcvd_cnt    <= '0;
         lines_r     <= '0;
         base_addr   <= '0;
         checksum    <= '0;
      end else begin
         tx_c0_valid <= issue;
         if (start_pulse && !busy) begin      // Start while busy is ignored
            sent_cnt  <= '0;
            rcvd_cnt  <= '0;
            lines_r   <= num_lines;
            base_addr <= src_addr;
            checksum  <= '0;
            busy      <= (num_lines != '0);
            done      <= (num_lines == '0);   // Empty job ends at once
         end else if (busy) begin
            if (issue)
               sent_cnt <= sent_cnt + 1'b1;
            if (rsp_strb) begin
               rcvd_cnt <= rcvd_cnt + 1'b1;
               checksum <= checksum + rsp_data;   // Wraps mod 2^64
            end
            // Last response counted last cycle
            if (rcvd_cnt == lines_r) begin
               busy <= 1'b0;
               done <= 1'b1;                  // Held until next start
            end
         end
      end
   end

   // Request fields, index as tag
   always_ff @(posedge pClk) begin
      if (issue) begin
         tx_c0_addr  <= base_addr + line_idx;
         tx_c0_mdata <= {{(ccip_if_pkg::mdata_w - afu_csr_pkg::max_lines_w){1'b0}},
                         sent_cnt};
      end
   end

   // Back-pressure honoured one cycle on
   a_almfull: assert property (@(posedge pClk) disable iff (!arst_n)
      tx_c0_valid |-> !$past(rx_c0_almfull));

   // Host never returns more lines than were asked for
   a_rcvd_le_sent: assert property (@(posedge pClk) disable iff (!arst_n)
      rcvd_cnt <= sent_cnt);

endmodule

// File: afu_top.sv
/* AFU top level. Connects the receive demux, CSR file and read engine
   to the host channel ports */
`timescale 1ns/1ps

module afu_top (
   input  logic                                pClk,
   input  logic                                arst_n,
   input  logic                                rx_c0_valid,
   input  ccip_if_pkg::t_c0_rx_hdr             rx_c0_hdr,
   input  logic [ccip_if_pkg::data_w-1:0]      rx_c0_data,
   input  logic                                rx_c0_almfull,
   output logic                                tx_c0_valid,
   output logic [ccip_if_pkg::line_addr_w-1:0] tx_c0_addr,
   output logic [ccip_if_pkg::mdata_w-1:0]     tx_c0_mdata,
   output logic                                tx_c2_valid,
   output logic [ccip_if_pkg::tid_w-1:0]       tx_c2_tid,
   output logic [ccip_if_pkg::data_w-1:0]      tx_c2_data
);

   // Demux to CSR file
   logic                                mmio_rd_strb;
   logic                                mmio_wr_strb;
   logic [ccip_if_pkg::mmio_addr_w-1:0] mmio_addr;
   logic [ccip_if_pkg::tid_w-1:0]       mmio_tid;
   logic [ccip_if_pkg::data_w-1:0]      mmio_wdata;

   // Demux to engine
   logic                                rsp_strb;
   logic [ccip_if_pkg::data_w-1:0]      rsp_data;

   // CSR file and engine
   logic                                start_pulse;
   logic [ccip_if_pkg::line_addr_w-1:0] src_addr;
   logic [afu_csr_pkg::max_lines_w-1:0] num_lines;
   logic                                busy;
   logic                                done;
   logic [ccip_if_pkg::data_w-1:0]      checksum;

   c0_rx_demux demux_i (
      .pClk         (pClk),
      .arst_n       (arst_n),
      .rx_c0_valid  (rx_c0_valid),
      .rx_c0_hdr    (rx_c0_hdr),
      .rx_c0_data   (rx_c0_data),
      .mmio_rd_strb (mmio_rd_strb),
      .mmio_wr_strb (mmio_wr_strb),
      .rsp_strb     (rsp_strb),
      .mmio_addr    (mmio_addr),
      .mmio_tid     (mmio_tid),
      .mmio_wdata   (mmio_wdata),
      .rsp_data     (rsp_data)
   );

   afu_csr_regs csr_i (
      .pClk         (pClk),
      .arst_n       (arst_n),
      .mmio_rd_strb (mmio_rd_strb),
      .mmio_wr_strb (mmio_wr_strb),
      .mmio_addr    (mmio_addr),
      .mmio_tid     (mmio_tid),
      .mmio_wdata   (mmio_wdata),
      .busy         (busy),
      .done         (done),
      .checksum     (checksum),
      .start_pulse  (start_pulse),
      .src_addr     (src_addr),
      .num_lines    (num_lines),
      .tx_c2_valid  (tx_c2_valid),
      .tx_c2_tid    (tx_c2_tid),
      .tx_c2_data   (tx_c2_data)
   );

   afu_read_engine engine_i (
      .pClk          (pClk),
      .arst_n        (arst_n),
      .start_pulse   (start_pulse),
      .src_addr      (src_addr),
      .num_lines     (num_lines),
      .rx_c0_almfull (rx_c0_almfull),
      .rsp_strb      (rsp_strb),
      .rsp_data      (rsp_data),
      .tx_c0_valid   (tx_c0_valid),
      .tx_c0_addr    (tx_c0_addr),
      .tx_c0_mdata   (tx_c0_mdata),
      .busy          (busy),
      .done          (done),
      .checksum      (checksum)
   );

endmodule

// File: c0_rx_demux.sv
/* Registers the c0 receive word and splits it into MMIO read, MMIO write
   and read response strobes, one cycle after rx_c0_valid */
`timescale 1ns/1ps

module c0_rx_demux (
   input  logic                                pClk,
   input  logic                                arst_n,
   input  logic                                rx_c0_valid,
   input  ccip_if_pkg::t_c0_rx_hdr             rx_c0_hdr,
   input  logic [ccip_if_pkg::data_w-1:0]      rx_c0_data,
   output logic                                mmio_rd_strb,
   output logic                                mmio_wr_strb,
   output logic                                rsp_strb,
   output logic [ccip_if_pkg::mmio_addr_w-1:0] mmio_addr,
   output logic [ccip_if_pkg::tid_w-1:0]       mmio_tid,
   output logic [ccip_if_pkg::data_w-1:0]      mmio_wdata,
   output logic [ccip_if_pkg::data_w-1:0]      rsp_data
);

   logic is_mmio_rd;
   logic is_mmio_wr;
   logic is_rsp;

   // Kind sits in the same bits of both views
   assign is_mmio_rd = rx_c0_valid && (rx_c0_hdr.mmio.kind == ccip_if_pkg::kind_mmio_rd);
   assign is_mmio_wr = rx_c0_valid && (rx_c0_hdr.mmio.kind == ccip_if_pkg::kind_mmio_wr);
   assign is_rsp     = rx_c0_valid && (rx_c0_hdr.rsp.kind == ccip_if_pkg::kind_rd_rsp);

   always_ff @(posedge pClk or negedge arst_n) begin
      if (!arst_n) begin
         mmio_rd_strb <= 1'b0;
         mmio_wr_strb <= 1'b0;
         rsp_strb     <= 1'b0;
      end else begin
         mmio_rd_strb <= is_mmio_rd;   // kind_none gives nothing
         mmio_wr_strb <= is_mmio_wr;
         rsp_strb     <= is_rsp;
      end
   end

   // Fields of the matching view, held until next match
   always_ff @(posedge pClk) begin
      if (is_mmio_rd || is_mmio_wr) begin
         mmio_addr <= rx_c0_hdr.mmio.addr;
         mmio_tid  <= rx_c0_hdr.mmio.tid;
      end
      if (is_mmio_wr)
         mmio_wdata <= rx_c0_data;     // Write payload
      if (is_rsp)
         rsp_data   <= rx_c0_data;     // Line data for the checksum
   end

   // One header kind per cycle, so at most one strobe
   a_strb_onehot: assert property (@(posedge pClk) disable iff (!arst_n)
      $onehot0({mmio_rd_strb, mmio_wr_strb, rsp_strb}));

endmodule

// File: ccip_if_pkg.sv
/* Host channel widths, header kind codes and the receive header views.
   Used by scoped name from every RTL block and from the testbench */
package ccip_if_pkg;

   localparam int data_w      = 64;   // Response and MMIO payload
   localparam int line_addr_w = 32;   // c0 read request address
   localparam int mmio_addr_w = 16;   // Dword MMIO address
   localparam int tid_w       = 9;    // MMIO transaction ID
   localparam int mdata_w     = 16;   // Request tag, echoed in response
   localparam int hdr_w       = 32;   // Receive header
   localparam int kind_w      = 2;
   localparam int rsp_type_w  = 4;

   // Padding so that both views fill hdr_w
   localparam int mmio_rsvd_w = hdr_w - kind_w - tid_w - mmio_addr_w;
   localparam int rsp_rsvd_w  = hdr_w - kind_w - rsp_type_w - mdata_w;

   // Kind codes, top two header bits in either view
   localparam logic [kind_w-1:0] kind_none    = 2'b00;
   localparam logic [kind_w-1:0] kind_mmio_rd = 2'b01;
   localparam logic [kind_w-1:0] kind_mmio_wr = 2'b10;
   localparam logic [kind_w-1:0] kind_rd_rsp  = 2'b11;

   // MMIO request view
   typedef struct packed {
      logic [kind_w-1:0]      kind;
      logic [mmio_rsvd_w-1:0] rsvd;
      logic [tid_w-1:0]       tid;    // Returned on c2
      logic [mmio_addr_w-1:0] addr;   // Dword offset
   } t_mmio_req_hdr;

   // Memory read response view
   typedef struct packed {
      logic [kind_w-1:0]      kind;
      logic [rsp_rsvd_w-1:0]  rsvd;
      logic [rsp_type_w-1:0]  rsp_type;
      logic [mdata_w-1:0]     mdata;  // Tag of the matching request
   } t_rd_rsp_hdr;

   // Same header word, decoded by kind
   typedef union packed {
      t_mmio_req_hdr mmio;
      t_rd_rsp_hdr   rsp;
   } t_c0_rx_hdr;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_top -f tb.f -o tb_sim \
   && ./obj_dir/tb_sim \
   || { echo "simulation run failed"; exit 1; }

// File: tb.f
ccip_if_pkg.sv
afu_csr_pkg.sv
c0_rx_demux.sv
afu_csr_regs.sv
afu_read_engine.sv
afu_top.sv
tb_top.sv

// File: tb_stimulus.txt
# op offset value expected, all hex. W writes value, R reads and compares with expected,
# G writes value to offset to start a job, waits for done and expects that checksum
R 0000 0 5eedac1e0c0d0001
R 000a 0 0
R 000c 0 0
W 0002 0123456789abcdef 0
R 0002 0 0123456789abcdef
W 0002 fedcba9876543210 0
R 0002 0 fedcba9876543210
W 0000 ffffffffffffffff 0
R 0000 0 5eedac1e0c0d0001
W 000c 1234 0
R 000c 0 0
W 000a 3 0
R 000a 0 0
R 0008 0 0
R 000e 0 0
R 0020 0 0
W 0004 100 0
W 0006 4 0
R 0004 0 100
R 0006 0 4
G 0008 1 c16
W 0006 0 0
G 0008 1 0
W 0004 2000 0
W 0006 10 0
G 0008 1 60178
W 0004 fffffffe 0
W 0006 3 0
G 0008 1 5fffffffa
W 0004 0 0
W 0006 ff 0
G 0008 1 17c82
W 0004 100 0
W 0006 4 0
G 0008 1 c16
R 0002 0 fedcba9876543210

// File: tb_top.sv
/* Testbench for the AFU top level. Plays MMIO operations from the stimulus
   file and models host memory that answers line reads after random gaps */
`timescale 1ns/1ps

module tb_top;

   localparam int timeout_cyc = 2000;   // Limit for every wait loop

   // DUT inputs, idle from time zero
   logic                                pClk          = 1'b0;
   logic                                arst_n        = 1'b0;
   logic                                rx_c0_valid   = 1'b0;
   ccip_if_pkg::t_c0_rx_hdr             rx_c0_hdr     = '0;
   logic [ccip_if_pkg::data_w-1:0]      rx_c0_data    = '0;
   logic                                rx_c0_almfull = 1'b0;
   // DUT outputs
   logic                                tx_c0_valid;
   logic [ccip_if_pkg::line_addr_w-1:0] tx_c0_addr;
   logic [ccip_if_pkg::mdata_w-1:0]     tx_c0_mdata;
   logic                                tx_c2_valid;
   logic [ccip_if_pkg::tid_w-1:0]       tx_c2_tid;
   logic [ccip_if_pkg::data_w-1:0]      tx_c2_data;

   int unsigned                         cyc          = 0;   // Rising edges so far
   int unsigned                         mmio_req_no  = 0;   // Raised by the main process
   int unsigned                         mmio_sent_no = 0;   // Caught up by the host driver
   int unsigned                         mmio_cyc     = 0;   // Cycle the request went out
   ccip_if_pkg::t_c0_rx_hdr             mmio_hdr     = '0;
   logic [ccip_if_pkg::data_w-1:0]      mmio_wdata   = '0;

   // Job model, shadowed from MMIO writes
   logic [ccip_if_pkg::line_addr_w-1:0] exp_base  = '0;
   int unsigned                         exp_lines = 0;
   int unsigned                         job_first = 0;    // req_total at job start
   int unsigned                         req_total = 0;    // Line requests seen
   int unsigned                         line_idx;

   // Responses owed to the AFU, in request order
   int unsigned                         rsp_due[$];
   logic [ccip_if_pkg::mdata_w-1:0]     rsp_mdata[$];
   logic [ccip_if_pkg::data_w-1:0]      rsp_word[$];

   always #20 pClk = ~pClk;                      // 40 ns period

   always @(posedge pClk) cyc <= cyc + 1;

   afu_top dut_i (
      .pClk          (pClk),
      .arst_n        (arst_n),
      .rx_c0_valid   (rx_c0_valid),
      .rx_c0_hdr     (rx_c0_hdr),
      .rx_c0_data    (rx_c0_data),
      .rx_c0_almfull (rx_c0_almfull),
      .tx_c0_valid   (tx_c0_valid),
      .tx_c0_addr    (tx_c0_addr),
      .tx_c0_mdata   (tx_c0_mdata),
      .tx_c2_valid   (tx_c2_valid),
      .tx_c2_tid     (tx_c2_tid),
      .tx_c2_data    (tx_c2_data)
   );

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_mmio(input logic [ccip_if_pkg::tid_w-1:0]  exp_tid,
                             input logic [ccip_if_pkg::data_w-1:0] exp_data);
      if (tx_c2_tid !== exp_tid)
         abort_run($sformatf("Fail at %0t: tx_c2_tid expected %h got %h",
                             $time, exp_tid, tx_c2_tid));
      if (tx_c2_data !== exp_data)
         abort_run($sformatf("Fail at %0t: tx_c2_data expected %h got %h",
                             $time, exp_data, tx_c2_data));
   endtask

   task automatic check_line_req(input logic [ccip_if_pkg::line_addr_w-1:0] exp_addr,
                                 input logic [ccip_if_pkg::mdata_w-1:0]     exp_mdata);
      if (tx_c0_addr !== exp_addr)
         abort_run($sformatf("Fail at %0t: tx_c0_addr expected %h got %h",
                             $time, exp_addr, tx_c0_addr));
      if (tx_c0_mdata !== exp_mdata)
         abort_run($sformatf("Fail at %0t: tx_c0_mdata expected %h got %h",
                             $time, exp_mdata, tx_c0_mdata));
   endtask

   task automatic skip_cycles(input int n);
      repeat (n) @(negedge pClk);
   endtask

   // Hand one MMIO request to the host driver, wait until it is on the bus
   task automatic send_mmio(input logic [ccip_if_pkg::kind_w-1:0]      kind,
                            input logic [ccip_if_pkg::mmio_addr_w-1:0] off,
                            input logic [ccip_if_pkg::data_w-1:0]      wdata,
                            input logic [ccip_if_pkg::tid_w-1:0]       tid);
      int unsigned t0;
      mmio_hdr           = '0;
      mmio_hdr.mmio.kind = kind;
      mmio_hdr.mmio.tid  = tid;
      mmio_hdr.mmio.addr = off;
      mmio_wdata         = wdata;
      mmio_req_no++;
      t0 = cyc;
      while (mmio_sent_no != mmio_req_no) begin
         @(negedge pClk);
         if (cyc - t0 > timeout_cyc)
            abort_run("MMIO request was never driven onto the receive channel");
      end
   endtask

   task automatic mmio_write(input logic [ccip_if_pkg::mmio_addr_w-1:0] off,
                             input logic [ccip_if_pkg::data_w-1:0]      wdata);
      send_mmio(ccip_if_pkg::kind_mmio_wr, off, wdata, '0);
   endtask

   // Random tid, response due exactly two cycles after the request
   task automatic read_csr(input  logic [ccip_if_pkg::mmio_addr_w-1:0] off,
                           output logic [ccip_if_pkg::tid_w-1:0]       tid);
      logic [31:0] rnd;
      int unsigned t0;
      rnd = $urandom;
      tid = rnd[ccip_if_pkg::tid_w-1:0];
      send_mmio(ccip_if_pkg::kind_mmio_rd, off, '0, tid);
      t0 = cyc;
      while (!tx_c2_valid) begin
         @(negedge pClk);
         if (cyc - t0 > timeout_cyc)
            abort_run("no MMIO read response within the timeout");
      end
      if (cyc - mmio_cyc != 2)
         abort_run($sformatf("MMIO read response came %0d cycles after the request, not 2",
                             cyc - mmio_cyc));
   endtask

   task automatic read_and_check(input logic [ccip_if_pkg::mmio_addr_w-1:0] off,
                                 input logic [ccip_if_pkg::data_w-1:0]      exp_data);
      logic [ccip_if_pkg::tid_w-1:0] tid;
      read_csr(off, tid);
      check_mmio(tid, exp_data);
   endtask

   // Poll status, running is busy only, finished is done only
   task automatic wait_job_done();
      logic [ccip_if_pkg::tid_w-1:0] tid;
      int unsigned t0;
      t0 = cyc;
      read_csr(afu_csr_pkg::csr_status, tid);
      while (tx_c2_data != 64'h1) begin
         check_mmio(tid, 64'h2);
         if (cyc - t0 > timeout_cyc)
            abort_run("read job did not report done within the timeout");
         read_csr(afu_csr_pkg::csr_status, tid);
      end
      check_mmio(tid, 64'h1);
   endtask

   task automatic run_job(input logic [ccip_if_pkg::mmio_addr_w-1:0] off,
                          input logic [ccip_if_pkg::data_w-1:0]      ctrl,
                          input logic [ccip_if_pkg::data_w-1:0]      exp_sum);
      job_first = req_total;
      mmio_write(off, ctrl);
      skip_cycles(2);                            // Start reaches the engine first
      wait_job_done();
      if (req_total - job_first != exp_lines)
         abort_run($sformatf("job sent %0d line requests instead of %0d",
                             req_total - job_first, exp_lines));
      read_and_check(afu_csr_pkg::csr_checksum, exp_sum);
   endtask

   // Host side: check line requests, then drive the receive channel
   always @(posedge pClk) begin
      #2;
      if (arst_n && tx_c0_valid) begin
         if (rx_c0_almfull)                      // Still last cycle's level here
            abort_run("line request issued after a cycle with almfull high");
         line_idx = req_total - job_first;
         if (line_idx >= exp_lines)
            abort_run("line request beyond the programmed line count");
         check_line_req(exp_base + line_idx, line_idx[ccip_if_pkg::mdata_w-1:0]);
         rsp_due.push_back(cyc + 1 + ($urandom % 4));   // Random memory latency
         rsp_mdata.push_back(tx_c0_mdata);
         rsp_word.push_back({32'b0, tx_c0_addr} * 64'd3 + 64'd1);
         req_total++;
      end
      rx_c0_almfull = ($urandom % 4) == 0;       // About one cycle in four
      rx_c0_valid   = 1'b0;
      rx_c0_hdr     = '0;
      rx_c0_data    = '0;
      if (mmio_sent_no != mmio_req_no) begin     // MMIO wins the channel
         rx_c0_valid  = 1'b1;
         rx_c0_hdr    = mmio_hdr;
         rx_c0_data   = mmio_wdata;
         mmio_cyc     = cyc;
         mmio_sent_no = mmio_req_no;
      end else if (rsp_due.size() != 0 && rsp_due[0] <= cyc) begin
         rx_c0_valid         = 1'b1;
         rx_c0_hdr.rsp.kind  = ccip_if_pkg::kind_rd_rsp;
         rx_c0_hdr.rsp.mdata = rsp_mdata.pop_front();
         rx_c0_data          = rsp_word.pop_front();
         rsp_due.delete(0);
      end
   end

   initial begin
      string line;
      int    fd;
      int    rc;
      byte   op;
      logic [ccip_if_pkg::mmio_addr_w-1:0] off;
      logic [ccip_if_pkg::data_w-1:0]      val;
      logic [ccip_if_pkg::data_w-1:0]      expv;
      void'($urandom(57));
      arst_n = 1'b0;
      repeat (8) @(posedge pClk);
      #2 arst_n = 1'b1;
      fd = $fopen("tb_stimulus.txt", "r");
      if (fd == 0)
         abort_run("cannot open tb_stimulus.txt");
      while (!$feof(fd)) begin
         line = "";
         rc   = $fgets(line, fd);
         if (line.len() < 2 || line[0] == "#")  // Blank or comment
            continue;
         op = line[0];
         rc = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", off, val, expv);
         if (rc != 3)
            abort_run($sformatf("malformed stimulus line: %s", line));
         if (op == "W") begin
            mmio_write(off, val);
            if (off == afu_csr_pkg::csr_src_addr)
               exp_base = val[ccip_if_pkg::line_addr_w-1:0];
            if (off == afu_csr_pkg::csr_num_lines)
               exp_lines = int'(val[afu_csr_pkg::max_lines_w-1:0]);
         end else if (op == "R") begin
            read_and_check(off, expv);
         end else if (op == "G") begin
            run_job(off, val, expv);
         end else begin
            abort_run($sformatf("unknown operation in stimulus line: %s", line));
         end
      end
      $fclose(fd);
      $display("Finished with no errors");
      $finish;
   end

endmodule
